// ==== hdl/audio_pkg.sv ====
package audio_pkg;

    // bit clock periods in one channel word, fixed by the frame format
    localparam int SLOT_BITS = 32;

    // widest sample the data path carries
    // narrower builds keep their bits at the top of this field
    localparam int SAMPLE_W = 24;

    // direction of one serial engine
    typedef enum logic {
        CODEC_RX = 1'b0,
        CODEC_TX = 1'b1
    } codec_mode_e;

    // bit clock bundle, one generator feeds both directions
    typedef struct packed {
        // bit clock level as driven on the pin
        logic sck;
        // word select level as driven on the pin
        logic ws;
        // single cycle strobe, sck has just gone high
        logic sck_rise;
        // single cycle strobe, sck has just gone low
        logic sck_fall;
        // fall that opens the delay bit period of a new word
        logic word_start;
        // channel of the word being opened, 0 left 1 right
        logic chan;
    } i2s_timing_t;

    // one audio word on the internal data path
    typedef struct packed {
        // 0 left, 1 right
        logic                       chan;
        // two's complement, msb aligned
        logic signed [SAMPLE_W-1:0] data;
    } audio_sample_t;

endpackage

// ==== hdl/i2s_clock_gen.sv ====
`timescale 1ns/1ps

module i2s_clock_gen #(
    parameter int CLK_RATIO = 4,
    parameter int SWAP_LR   = 0
) (
    input  logic                   lmmi_clk_i,
    input  logic                   reset_n_i,
    output audio_pkg::i2s_timing_t timing_o
);

    import audio_pkg::*;

    localparam int HALF_W = $clog2(CLK_RATIO);
    localparam int BIT_W  = $clog2(SLOT_BITS);

    // hold for one cycle, wait for the first fall, then free running
    typedef enum logic [1:0] {
        GEN_HOLD,
        GEN_LEAD,
        GEN_RUN
    } gen_state_e;

    gen_state_e        state_q;
    logic [HALF_W-1:0] half_cnt_q;
    logic [BIT_W-1:0]  bit_cnt_q;
    i2s_timing_t       tim_q;
    logic              half_done;
    logic              word_end;
    logic              ws_next;

    // last system cycle of a half bit period
    assign half_done = (half_cnt_q == HALF_W'(CLK_RATIO - 1));
    // very first fall after reset, or the fall closing bit SLOT_BITS-1
    assign word_end  = (state_q == GEN_LEAD) || (bit_cnt_q == BIT_W'(SLOT_BITS - 1));
    // first word keeps ws low, after that ws flips on every word
    assign ws_next   = (state_q == GEN_RUN) ? ~tim_q.ws : tim_q.ws;

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            state_q    <= GEN_HOLD;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tim_q      <= '0;
        end else begin
            // strobes default low, set only on the edge cycle
            tim_q.sck_rise   <= 1'b0;
            tim_q.sck_fall   <= 1'b0;
            tim_q.word_start <= 1'b0;
            if (state_q == GEN_HOLD) begin
                state_q <= GEN_LEAD;
            end else if (half_done) begin
                half_cnt_q <= '0;
                tim_q.sck  <= ~tim_q.sck;
                if (!tim_q.sck) begin
                    tim_q.sck_rise <= 1'b1;
                end else begin
                    tim_q.sck_fall <= 1'b1;
                    if (word_end) begin
                        // ws moves one bit ahead of the msb
                        state_q          <= GEN_RUN;
                        bit_cnt_q        <= '0;
                        tim_q.ws         <= ws_next;
                        tim_q.chan       <= ws_next ^ 1'(SWAP_LR);
                        tim_q.word_start <= 1'b1;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
        end
    end

    assign timing_o = tim_q;

    // codecs only open a word on a falling bit clock edge
    assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
        timing_o.word_start |-> timing_o.sck_fall);

    // rise and fall strobes are exclusive
    assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
        !(timing_o.sck_rise && timing_o.sck_fall));

endmodule

// ==== hdl/i2s_codec.sv ====
`timescale 1ns/1ps

module i2s_codec #(
    parameter audio_pkg::codec_mode_e MODE        = audio_pkg::CODEC_RX,
    parameter int                     SAMPLE_BITS = 24
) (
    input  logic                     lmmi_clk_i,
    input  logic                     reset_n_i,
    input  audio_pkg::i2s_timing_t   timing_i,
    input  logic                     i2s_sd_i,
    input  audio_pkg::audio_sample_t tx_sample_i,
    output audio_pkg::audio_sample_t rx_sample_o,
    output logic                     rx_valid_o,
    output logic                     i2s_sd_o
);

    import audio_pkg::*;

    localparam int CNT_W = $clog2(SLOT_BITS);

    if (MODE == CODEC_RX) begin : g_rx

        logic [SAMPLE_W-1:0] shift_q;
        logic [CNT_W-1:0]    bit_cnt_q;
        logic                active_q;
        logic                chan_q;
        logic                valid_q;
        logic                take_bit;
        logic                last_bit;

        // rise 0 of a word is the delay bit, rises 1..SAMPLE_BITS carry data
        assign take_bit = timing_i.sck_rise && active_q && (bit_cnt_q != '0);
        assign last_bit = take_bit && (bit_cnt_q == CNT_W'(SAMPLE_BITS));

        always_ff @(posedge lmmi_clk_i) begin
            if (!reset_n_i) begin
                bit_cnt_q <= '0;
                active_q  <= 1'b0;
                chan_q    <= 1'b0;
                valid_q   <= 1'b0;
            end else begin
                // one cycle after the rise that took the lsb
                valid_q <= last_bit;
                if (timing_i.word_start) begin
                    bit_cnt_q <= '0;
                    active_q  <= 1'b1;
                    chan_q    <= timing_i.chan;
                end else if (timing_i.sck_rise && active_q) begin
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                    // padding bits after the field are ignored
                    if (last_bit) begin
                        active_q <= 1'b0;
                    end
                end
            end
        end

        // msb first, so the word builds up from the lsb side
        always_ff @(posedge lmmi_clk_i) begin
            if (take_bit) begin
                shift_q <= {shift_q[SAMPLE_W-2:0], i2s_sd_i};
            end
        end

        // move the SAMPLE_BITS field up so the sign lands in the msb
        assign rx_sample_o = '{chan: chan_q, data: shift_q << (SAMPLE_W - SAMPLE_BITS)};
        assign rx_valid_o  = valid_q;
        // receiver never drives the serial output
        assign i2s_sd_o    = 1'b0;

        // one pulse per received word
        assert property (@(posedge lmmi_clk_i) disable iff (!reset_n_i)
            rx_valid_o |=> !rx_valid_o);

    end else begin : g_tx

        logic [SAMPLE_W-1:0] shift_q;
        logic [CNT_W-1:0]    bit_cnt_q;
        logic                sd_q;
        logic                field_done;

        // SAMPLE_BITS bits sent, rest of the slot is zero
        assign field_done = (bit_cnt_q == CNT_W'(SAMPLE_BITS));

        always_ff @(posedge lmmi_clk_i) begin
            if (!reset_n_i) begin
                // idle as if a word just finished, so only zeros go out
                bit_cnt_q <= CNT_W'(SAMPLE_BITS);
                sd_q      <= 1'b0;
            end else begin
                if (timing_i.word_start) begin
                    // delay bit period
                    bit_cnt_q <= '0;
                    sd_q      <= 1'b0;
                end else if (timing_i.sck_fall) begin
                    if (!field_done) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        sd_q      <= shift_q[SAMPLE_W-1];
                    end else begin
                        sd_q <= 1'b0;
                    end
                end
            end
        end

        // word loaded at its start, walked out msb first
        always_ff @(posedge lmmi_clk_i) begin
            if (timing_i.word_start) begin
                shift_q <= tx_sample_i.data;
            end else if (timing_i.sck_fall && !field_done) begin
                shift_q <= {shift_q[SAMPLE_W-2:0], 1'b0};
            end
        end

        assign i2s_sd_o    = sd_q;
        // transmitter has no receive side
        assign rx_sample_o = '0;
        assign rx_valid_o  = 1'b0;

    end

endmodule

// ==== hdl/sample_scaler.sv ====
`timescale 1ns/1ps

module sample_scaler #(
    parameter int ATTEN_SHIFT = 5
) (
    input  logic                     lmmi_clk_i,
    input  logic                     reset_n_i,
    input  audio_pkg::audio_sample_t sample_i,
    input  logic                     valid_i,
    output audio_pkg::audio_sample_t sample_o,
    output logic                     valid_o
);

    import audio_pkg::*;

    logic signed [SAMPLE_W-1:0] shifted;

    // attenuation by 2^ATTEN_SHIFT, sign bits fill from the top
    assign shifted = $signed(sample_i.data) >>> ATTEN_SHIFT;

    // valid follows the input by one cycle
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // hold the last scaled word until the next one arrives
    always_ff @(posedge lmmi_clk_i) begin
        if (valid_i) begin
            sample_o.chan <= sample_i.chan;
            sample_o.data <= shifted;
        end
    end

endmodule

// ==== hdl/audio_filter.sv ====
`timescale 1ns/1ps

module audio_filter (
    input  logic                     lmmi_clk_i,
    input  logic                     reset_n_i,
    input  audio_pkg::audio_sample_t sample_i,
    input  logic                     valid_i,
    output audio_pkg::audio_sample_t sample_o,
    output logic                     valid_o,
    input  logic                     tx_chan_i,
    output audio_pkg::audio_sample_t tx_sample_o
);

    import audio_pkg::*;

    // index 0 left, index 1 right
    logic signed [SAMPLE_W-1:0] prev_q [2];
    logic signed [SAMPLE_W-1:0] held_q [2];
    logic signed [SAMPLE_W:0]   sum;
    logic signed [SAMPLE_W-1:0] avg;
    logic                       ch;

    assign ch  = sample_i.chan;

    // one extra bit of headroom, two full scale inputs still fit
    assign sum = $signed(sample_i.data) + prev_q[ch];

    // halve back into the sample width
    assign avg = SAMPLE_W'(sum >>> 1);

    // history and held output are per channel
    // the other channel's registers stay untouched
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            prev_q  <= '{default: '0};
            held_q  <= '{default: '0};
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                prev_q[ch] <= sample_i.data;
                held_q[ch] <= avg;
            end
        end
    end

    // filtered stream, one cycle behind the input
    always_ff @(posedge lmmi_clk_i) begin
        if (valid_i) begin
            sample_o.chan <= ch;
            sample_o.data <= avg;
        end
    end

    // transmitter picks the held value of the word it is opening
    // zero until that channel has seen its first input
    assign tx_sample_o = '{chan: tx_chan_i, data: held_q[tx_chan_i]};

endmodule

// ==== hdl/audio_loop_top.sv ====
`timescale 1ns/1ps

module audio_loop_top #(
    parameter int SAMPLE_BITS = 24,
    parameter int CLK_RATIO   = 4,
    parameter int SWAP_LR     = 0,
    parameter int ATTEN_SHIFT = 5
) (
    input  logic lmmi_clk_i,
    input  logic reset_n_i,
    input  logic i2s_sd_i,
    output logic i2s_sd_o,
    output logic i2s_sck_o,
    output logic i2s_ws_o
);

    import audio_pkg::*;

    // shared bit clock, both codecs run off it
    i2s_timing_t   timing;
    audio_sample_t rx_sample;
    logic          rx_valid;
    audio_sample_t scaled_sample;
    logic          scaled_valid;
    audio_sample_t filt_sample;
    logic          filt_valid;
    // held filter output for the channel the transmitter opens
    audio_sample_t tx_sample;

    i2s_clock_gen #(
        .CLK_RATIO (CLK_RATIO),
        .SWAP_LR   (SWAP_LR)
    ) clock_gen (
        .lmmi_clk_i (lmmi_clk_i),
        .reset_n_i  (reset_n_i),
        .timing_o   (timing)
    );

    // adc side
    i2s_codec #(
        .MODE        (CODEC_RX),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) i2s_rx (
        .lmmi_clk_i  (lmmi_clk_i),
        .reset_n_i   (reset_n_i),
        .timing_i    (timing),
        .i2s_sd_i    (i2s_sd_i),
        .tx_sample_i ('0),
        .rx_sample_o (rx_sample),
        .rx_valid_o  (rx_valid),
        .i2s_sd_o    ()
    );

    sample_scaler #(
        .ATTEN_SHIFT (ATTEN_SHIFT)
    ) scaler (
        .lmmi_clk_i (lmmi_clk_i),
        .reset_n_i  (reset_n_i),
        .sample_i   (rx_sample),
        .valid_i    (rx_valid),
        .sample_o   (scaled_sample),
        .valid_o    (scaled_valid)
    );

    audio_filter filter (
        .lmmi_clk_i  (lmmi_clk_i),
        .reset_n_i   (reset_n_i),
        .sample_i    (scaled_sample),
        .valid_i     (scaled_valid),
        .sample_o    (filt_sample),
        .valid_o     (filt_valid),
        .tx_chan_i   (timing.chan),
        .tx_sample_o (tx_sample)
    );

    // dac side
    i2s_codec #(
        .MODE        (CODEC_TX),
        .SAMPLE_BITS (SAMPLE_BITS)
    ) i2s_tx (
        .lmmi_clk_i  (lmmi_clk_i),
        .reset_n_i   (reset_n_i),
        .timing_i    (timing),
        .i2s_sd_i    (1'b0),
        .tx_sample_i (tx_sample),
        .rx_sample_o (),
        .rx_valid_o  (),
        .i2s_sd_o    (i2s_sd_o)
    );

    assign i2s_sck_o = timing.sck;
    assign i2s_ws_o  = timing.ws;

endmodule

// ==== test/tb_audio_loop.sv ====
`timescale 1ns/1ps

module tb_audio_loop;

    import audio_pkg::*;

    localparam int SAMPLE_BITS  = 24;
    localparam int CLK_RATIO    = 4;
    localparam int SWAP_LR      = 0;
    localparam int ATTEN_SHIFT  = 5;
    localparam int TABLE_FRAMES = 8;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_NS       = 10;
    // one extra silent input frame pushes the last table pair out
    localparam int RUN_WORDS    = 2 * (TABLE_FRAMES + 1);
    // a frame is 2 * SLOT_BITS bit periods of 2 * CLK_RATIO clocks
    localparam int TIMEOUT_NS   = (TABLE_FRAMES + 4) * 2 * SLOT_BITS * 2 * CLK_RATIO * CLK_NS
                                  + RESET_CYCLES * CLK_NS;

    // one row per input frame with the output expected one frame later
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] in_l;
        logic signed [SAMPLE_W-1:0] in_r;
        logic signed [SAMPLE_W-1:0] exp_l;
        logic signed [SAMPLE_W-1:0] exp_r;
    } frame_vec_t;

    logic       lmmi_clk_i;
    logic       reset_n_i;
    logic       i2s_sd_i;
    logic       i2s_sd_o;
    logic       i2s_sck_o;
    logic       i2s_ws_o;
    // pin levels one clock back so edges show up one cycle late
    logic       sck_d;
    logic       ws_d;
    logic       sck_fell;
    logic       sck_rose;
    frame_vec_t vec [TABLE_FRAMES];
    integer     seed = 32'h55a06c10;
    int         sample_errs = 0;
    int         level_errs = 0;
    int         count_errs = 0;
    int         fall_cnt;
    int         cyc_cnt;

    audio_loop_top #(
        .SAMPLE_BITS (SAMPLE_BITS),
        .CLK_RATIO   (CLK_RATIO),
        .SWAP_LR     (SWAP_LR),
        .ATTEN_SHIFT (ATTEN_SHIFT)
    ) audio_loop_top_i (
        .lmmi_clk_i (lmmi_clk_i),
        .reset_n_i  (reset_n_i),
        .i2s_sd_i   (i2s_sd_i),
        .i2s_sd_o   (i2s_sd_o),
        .i2s_sck_o  (i2s_sck_o),
        .i2s_ws_o   (i2s_ws_o)
    );

    initial begin
        lmmi_clk_i = 1'b0;
        forever #(CLK_NS / 2) lmmi_clk_i = ~lmmi_clk_i;
    end

    always @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            sck_d <= 1'b0;
            ws_d  <= 1'b0;
        end else begin
            sck_d <= i2s_sck_o;
            ws_d  <= i2s_ws_o;
        end
    end

    assign sck_fell = sck_d && !i2s_sck_o;
    assign sck_rose = !sck_d && i2s_sck_o;

    task automatic check_sample(input string name, input audio_sample_t got,
                                input audio_sample_t exp);
        if (got !== exp) begin
            sample_errs++;
            $display("Mismatch %s at %0t: got chan %h data %h, expected chan %h data %h",
                     name, $time, got.chan, got.data, exp.chan, exp.data);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            level_errs++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errs++;
            $display("Mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
        end
    endtask

    task automatic check_outputs_low(input string when);
        check_level({"i2s_sd_o ", when}, i2s_sd_o, 1'b0);
        check_level({"i2s_sck_o ", when}, i2s_sck_o, 1'b0);
        check_level({"i2s_ws_o ", when}, i2s_ws_o, 1'b0);
    endtask

    task automatic report_counts();
        $display("checks done: %0d sample errors, %0d level errors, %0d count errors",
                 sample_errs, level_errs, count_errs);
    endtask

    // quotient rounded toward minus infinity for a positive divisor
    function automatic int floor_div(input int n, input int d);
        int q;
        q = n / d;
        if ((n % d != 0) && (n < 0)) begin
            q = q - 1;
        end
        return q;
    endfunction

    // attenuation by 2^ATTEN_SHIFT rounds toward minus infinity
    function automatic int scale_ref(input logic signed [SAMPLE_W-1:0] x);
        return floor_div(int'(x), 1 << ATTEN_SHIFT);
    endfunction

    // mean of two taps taken from the full int sum and rounded down
    function automatic logic signed [SAMPLE_W-1:0] average_ref(input int cur, input int prev);
        return SAMPLE_W'(floor_div(cur + prev, 2));
    endfunction

    // word 0 after reset is the left word unless channels are swapped
    function automatic logic word_chan(input int w);
        return 1'((w % 2) ^ SWAP_LR);
    endfunction

    task automatic build_table();
        int prev_l;
        int prev_r;
        int cur_l;
        int cur_r;
        int f;
        vec[0].in_l = 24'h000000;
        vec[0].in_r = 24'h000000;
        vec[1].in_l = 24'h000640;
        vec[1].in_r = 24'h001a00;
        vec[2].in_l = 24'hfff000;
        vec[2].in_r = 24'hffc400;
        // full scale one way and then swapped
        vec[3].in_l = 24'h7fffff;
        vec[3].in_r = 24'h800000;
        vec[4].in_l = 24'h800000;
        vec[4].in_r = 24'h7fffff;
        vec[5].in_l = 24'h2aaaa0;
        vec[5].in_r = 24'hd55560;
        vec[6].in_l = SAMPLE_W'($random(seed));
        vec[6].in_r = SAMPLE_W'($random(seed));
        vec[7].in_l = SAMPLE_W'($random(seed));
        vec[7].in_r = SAMPLE_W'($random(seed));
        // filter history starts at zero
        prev_l = 0;
        prev_r = 0;
        for (f = 0; f < TABLE_FRAMES; f++) begin
            cur_l        = scale_ref(vec[f].in_l);
            cur_r        = scale_ref(vec[f].in_r);
            vec[f].exp_l = average_ref(cur_l, prev_l);
            vec[f].exp_r = average_ref(cur_r, prev_r);
            prev_l       = cur_l;
            prev_r       = cur_r;
        end
    endtask

    task automatic wait_fall();
        do begin
            @(posedge lmmi_clk_i);
        end while (!sck_fell);
    endtask

    task automatic wait_rise();
        do begin
            @(posedge lmmi_clk_i);
        end while (!sck_rose);
    endtask

    // period 0 is the delay slot and carries the last bit of the previous word
    task automatic drive_word(input int w);
        logic [SAMPLE_W-1:0] data;
        logic                bit_v;
        int                  p;
        data = '0;
        if (w / 2 < TABLE_FRAMES) begin
            data = word_chan(w) ? vec[w / 2].in_r : vec[w / 2].in_l;
        end
        for (p = 0; p < SLOT_BITS; p++) begin
            wait_fall();
            if (p >= 1 && p <= SAMPLE_BITS) begin
                bit_v = data[SAMPLE_W - p];
            end else begin
                // padding carries junk that the receiver must drop
                bit_v = 1'($random(seed));
            end
            i2s_sd_i <= bit_v;
        end
    endtask

    task automatic capture_word(input int w);
        audio_sample_t       got;
        audio_sample_t       exp;
        logic [SAMPLE_W-1:0] data;
        logic                ch;
        int                  p;
        data = '0;
        ch   = 1'b0;
        for (p = 0; p < SLOT_BITS; p++) begin
            wait_rise();
            if (p >= 1 && p <= SAMPLE_BITS) begin
                data[SAMPLE_W - p] = i2s_sd_o;
            end else begin
                check_level($sformatf("i2s_sd_o pad bit %0d of word %0d", p, w), i2s_sd_o, 1'b0);
            end
            if (p == 1) begin
                ch = i2s_ws_o ^ 1'(SWAP_LR);
            end
        end
        got.chan = ch;
        got.data = data;
        exp.chan = word_chan(w);
        exp.data = '0;
        // frame 0 goes out before any input has been filtered
        if (w >= 2) begin
            exp.data = exp.chan ? vec[w / 2 - 1].exp_r : vec[w / 2 - 1].exp_l;
        end
        check_sample($sformatf("i2s_sd_o word %0d", w), got, exp);
    endtask

    task automatic run_source();
        int w;
        for (w = 0; w < RUN_WORDS; w++) begin
            drive_word(w);
        end
    endtask

    task automatic run_capture();
        int w;
        // skip the lone rise before the first word opens
        wait_fall();
        for (w = 0; w < RUN_WORDS; w++) begin
            capture_word(w);
        end
    endtask

    // bit clock period and word select placement
    always @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            fall_cnt = 0;
            cyc_cnt  = 0;
        end else if (sck_fell) begin
            if (fall_cnt > 0) begin
                check_count("sck period", cyc_cnt + 1, 2 * CLK_RATIO);
            end
            check_level("i2s_ws_o at sck fall", i2s_ws_o, 1'((fall_cnt / SLOT_BITS) % 2));
            fall_cnt++;
            cyc_cnt = 0;
        end else begin
            // ws may only move together with sck falling
            check_level("i2s_ws_o between falls", i2s_ws_o, ws_d);
            cyc_cnt++;
        end
    end

    initial begin
        int i;
        reset_n_i <= 1'b0;
        i2s_sd_i  <= 1'b0;
        build_table();
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge lmmi_clk_i);
            if (i > 0) begin
                check_outputs_low("in reset");
            end
            if (i == RESET_CYCLES - 1) begin
                reset_n_i <= 1'b1;
            end
        end
        @(posedge lmmi_clk_i);
        @(posedge lmmi_clk_i);
        check_outputs_low("after reset");
        fork
            run_source();
            run_capture();
        join
        report_counts();
        if (sample_errs + level_errs + count_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the I2S frames did not complete within %0d ns", TIMEOUT_NS);
        report_counts();
        $display("test failed");
        $finish;
    end

endmodule

// ==== compile.f ====
hdl/audio_pkg.sv
hdl/i2s_clock_gen.sv
hdl/i2s_codec.sv
hdl/sample_scaler.sv
hdl/audio_filter.sv
hdl/audio_loop_top.sv
test/tb_audio_loop.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the audio loop testbench with verilator

cd "$(dirname "$0")" || exit 1

# warnings are still printed, they just do not stop the build
verilator --binary --assert -Wno-fatal --top-module tb_audio_loop \
    -f compile.f -o tb_audio_loop
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_audio_loop 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only when the testbench printed its pass line
if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1
